//--- breakout_defs.svh
`ifndef BREAKOUT_DEFS_SVH
`define BREAKOUT_DEFS_SVH

// screen
`define SCREEN_W 640
`define SCREEN_H 480

// ball
`define BALL_SIZE 10
`define BALL_DX 1
`define BALL_DY 3
`define BALL_START_X 300
`define BALL_START_Y 200

// paddle
`define BAR_W 96
`define BAR_H 25
`define BAR_Y 450
`define BAR_STEP 3
`define BAR_START_X 272

`define WALL_MARGIN 4
`define LOSE_Y 470

// block grid, last column runs to the right edge
`define BLOCK_COLS 6
`define BLOCK_ROWS 3
`define BLOCK_PITCH_X 107
`define BLOCK_W 104
`define BLOCK_PITCH_Y 55
`define BLOCK_H 50

`define TICK_CYCLES_DEFAULT 500000

`endif

//--- breakout_pkg.sv
`include "breakout_defs.svh"

package breakout_pkg;

	typedef logic [9:0] px_x_t;
	typedef logic [8:0] px_y_t;
	typedef logic [3:0] color_t;

	// bit 6r+c is row r, column c
	typedef logic [`BLOCK_ROWS*`BLOCK_COLS-1:0] block_map_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SETUP,
		ST_PLAYING,
		ST_OVER
	} game_state_t;

endpackage

//--- game_bus_if.sv
interface game_bus_if;
	import breakout_pkg::*;

	game_state_t state;
	logic tick;
	px_x_t bar_x;
	px_x_t ball_x;
	px_y_t ball_y;
	logic ball_lost;
	block_map_t block_on;
	logic hit;
	logic all_clear;

	modport control (output state, tick, input ball_lost, all_clear);

	modport paddle (input state, tick, output bar_x);

	modport ball (input state, tick, bar_x, hit, output ball_x, ball_y, ball_lost);

	modport blocks (input state, tick, ball_x, ball_y, output block_on, hit, all_clear);

	modport render (input state, bar_x, ball_x, ball_y, block_on, all_clear);

endinterface

//--- game_control.sv
`include "breakout_defs.svh"

module game_control #(
	parameter int unsigned TICK_CYCLES = `TICK_CYCLES_DEFAULT
) (
	input logic clk,
	input logic rst,
	input logic start,
	input logic serve,
	game_bus_if.control bus
);
	import breakout_pkg::*;

	localparam int unsigned TW = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;
	localparam logic [TW-1:0] LAST = TW'(TICK_CYCLES - 1);

	game_state_t state;
	game_state_t next_state;
	logic [TW-1:0] timer;

	// frame step timer, free running in every state
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			timer <= '0;
			state <= ST_IDLE;
		end
		else
		begin
			timer <= (timer == LAST) ? '0 : timer + 1'b1;
			state <= next_state;
		end
	end

	always_comb
	begin
		next_state = state;
		case (state)
			ST_IDLE: if (start) next_state = ST_SETUP;
			ST_SETUP: if (serve) next_state = ST_PLAYING;
			// lost or cleared ends the round
			ST_PLAYING: if (bus.ball_lost || bus.all_clear) next_state = ST_OVER;
			ST_OVER: if (start) next_state = ST_IDLE;
			default: next_state = ST_IDLE;
		endcase
	end

	assign bus.state = state;
	assign bus.tick = (timer == LAST);

endmodule

//--- paddle_ctrl.sv
`include "breakout_defs.svh"

module paddle_ctrl (
	input logic clk,
	input logic rst,
	input logic left,
	input logic right,
	game_bus_if.paddle bus
);
	import breakout_pkg::*;

	px_x_t bar_x;

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			bar_x <= px_x_t'(`BAR_START_X);
		end
		else if (bus.state == ST_IDLE || bus.state == ST_SETUP)
		begin
			bar_x <= px_x_t'(`BAR_START_X);
		end
		else if (bus.state == ST_PLAYING && bus.tick)
		begin
			// left takes priority when both keys are allowed
			if (left && bar_x >= `WALL_MARGIN)
			begin
				bar_x <= bar_x - px_x_t'(`BAR_STEP);
			end
			else if (right && bar_x + `BAR_W <= `SCREEN_W - 1)
			begin
				bar_x <= bar_x + px_x_t'(`BAR_STEP);
			end
		end
	end

	assign bus.bar_x = bar_x;

endmodule

//--- ball_motion.sv
`include "breakout_defs.svh"

module ball_motion (
	input logic clk,
	input logic rst,
	game_bus_if.ball bus
);
	import breakout_pkg::*;

	px_x_t ball_x;
	px_y_t ball_y;
	// 1 means right / down
	logic dir_x;
	logic dir_y;
	logic nx_dir;
	logic ny_dir;
	logic on_bar;

	assign on_bar = (ball_x >= bus.bar_x) && (ball_x <= bus.bar_x + `BAR_W)
		&& (ball_y >= `BAR_Y - `BALL_SIZE) && (ball_y <= `BAR_Y + `BAR_H - `BALL_SIZE);

	// direction from the old position, the move then uses it
	always_comb
	begin
		nx_dir = dir_x;
		if (ball_x + `BALL_SIZE >= `SCREEN_W - `WALL_MARGIN)
			nx_dir = 1'b0;
		else if (ball_x <= `WALL_MARGIN)
			nx_dir = 1'b1;

		ny_dir = dir_y;
		if (ball_y < `BALL_DY || bus.hit)
			ny_dir = 1'b1;
		else if (on_bar)
			ny_dir = 1'b0;
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			ball_x <= px_x_t'(`BALL_START_X);
			ball_y <= px_y_t'(`BALL_START_Y);
			dir_x <= 1'b1;
			dir_y <= 1'b1;
		end
		else if (bus.state == ST_IDLE || bus.state == ST_SETUP)
		begin
			ball_x <= px_x_t'(`BALL_START_X);
			ball_y <= px_y_t'(`BALL_START_Y);
			dir_x <= 1'b1;
			dir_y <= 1'b1;
		end
		else if (bus.state == ST_PLAYING && bus.tick)
		begin
			dir_x <= nx_dir;
			dir_y <= ny_dir;
			ball_x <= nx_dir ? ball_x + px_x_t'(`BALL_DX) : ball_x - px_x_t'(`BALL_DX);
			ball_y <= ny_dir ? ball_y + px_y_t'(`BALL_DY) : ball_y - px_y_t'(`BALL_DY);
		end
	end

	assign bus.ball_x = ball_x;
	assign bus.ball_y = ball_y;
	assign bus.ball_lost = (ball_y >= `LOSE_Y);

endmodule

//--- block_field.sv
`include "breakout_defs.svh"

module block_field (
	input logic clk,
	input logic rst,
	game_bus_if.blocks bus
);
	import breakout_pkg::*;

	block_map_t block_on;
	block_map_t in_box;

	// which block box holds the whole ball
	always_comb
	begin
		int bl;
		int br;
		int bt;
		in_box = '0;
		for (int r = 0; r < `BLOCK_ROWS; r++)
		begin
			for (int c = 0; c < `BLOCK_COLS; c++)
			begin
				bl = c * `BLOCK_PITCH_X;
				br = (c == `BLOCK_COLS - 1) ? `SCREEN_W : bl + `BLOCK_W;
				bt = r * `BLOCK_PITCH_Y;
				in_box[r*`BLOCK_COLS+c] = (bus.ball_x >= bl) && (bus.ball_x + `BALL_SIZE <= br)
					&& (bus.ball_y >= bt) && (bus.ball_y + `BALL_SIZE <= bt + `BLOCK_H);
			end
		end
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			block_on <= '1;
		else if (bus.state == ST_IDLE || bus.state == ST_SETUP)
			block_on <= '1;
		else if (bus.state == ST_PLAYING && bus.tick)
			block_on <= block_on & ~in_box;
	end

	assign bus.block_on = block_on;
	assign bus.hit = |(in_box & block_on);
	assign bus.all_clear = (block_on == '0);

endmodule

//--- pixel_render.sv
`include "breakout_defs.svh"

module pixel_render (
	input breakout_pkg::px_x_t x,
	input breakout_pkg::px_y_t y,
	output breakout_pkg::color_t vga_r,
	output breakout_pkg::color_t vga_g,
	output breakout_pkg::color_t vga_b,
	game_bus_if.render bus
);
	import breakout_pkg::*;

	localparam int STRIPES = `BALL_SIZE / 2;
	// round ball outline, inset per stripe
	localparam logic [STRIPES-1:0][1:0] BALL_INSET = {2'd3, 2'd2, 2'd0, 2'd2, 2'd3};
	// rgb per column: red yellow cyan green blue magenta
	localparam logic [`BLOCK_COLS-1:0][2:0] COL_RGB =
		{3'b101, 3'b001, 3'b010, 3'b011, 3'b110, 3'b100};

	logic ball_px;
	logic bar_px;
	logic sq_a;
	logic [2:0] blk_rgb;
	logic [2:0] rgb;

	always_comb
	begin
		ball_px = 1'b0;
		for (int k = 0; k < STRIPES; k++)
		begin
			if (y > bus.ball_y + 2 * k && y < bus.ball_y + 2 * k + 2
				&& x > bus.ball_x + BALL_INSET[k]
				&& x < bus.ball_x + `BALL_SIZE - BALL_INSET[k])
			begin
				ball_px = 1'b1;
			end
		end
	end

	assign bar_px = (x > bus.bar_x) && (x < bus.bar_x + `BAR_W)
		&& (y > `BAR_Y) && (y < `BAR_Y + `BAR_H);

	always_comb
	begin
		int bl;
		int br;
		int bt;
		blk_rgb = 3'b000;
		for (int r = 0; r < `BLOCK_ROWS; r++)
		begin
			for (int c = 0; c < `BLOCK_COLS; c++)
			begin
				bl = c * `BLOCK_PITCH_X;
				br = (c == `BLOCK_COLS - 1) ? `SCREEN_W : bl + `BLOCK_W;
				bt = r * `BLOCK_PITCH_Y;
				if (bus.block_on[r*`BLOCK_COLS+c] && x > bl && x < br
					&& y > bt && y < bt + `BLOCK_H)
				begin
					blk_rgb = blk_rgb | COL_RGB[c];
				end
			end
		end
	end

	assign sq_a = (x > 0) && (x < `SCREEN_W) && (y > 0) && (y < `SCREEN_H);

	always_comb
	begin
		case (bus.state)
			ST_SETUP, ST_PLAYING: rgb = {3{ball_px | bar_px}} | blk_rgb;
			// green on a win, red on a loss
			ST_OVER: rgb = bus.all_clear ? {1'b0, sq_a, 1'b0} : {sq_a, 2'b00};
			default: rgb = 3'b000;
		endcase
	end

	assign vga_r = {4{rgb[2]}};
	assign vga_g = {4{rgb[1]}};
	assign vga_b = {4{rgb[0]}};

endmodule

//--- breakout_top.sv
`include "breakout_defs.svh"

module breakout_top #(
	parameter int unsigned TICK_CYCLES = `TICK_CYCLES_DEFAULT
) (
	input logic clk,
	input logic rst,
	input breakout_pkg::px_x_t x,
	input breakout_pkg::px_y_t y,
	input logic left,
	input logic right,
	input logic start,
	input logic serve,
	output breakout_pkg::color_t vga_r,
	output breakout_pkg::color_t vga_g,
	output breakout_pkg::color_t vga_b
);

	game_bus_if bus ();

	game_control #(
		.TICK_CYCLES(TICK_CYCLES)
	) u_control (
		.clk(clk),
		.rst(rst),
		.start(start),
		.serve(serve),
		.bus(bus)
	);

	paddle_ctrl u_paddle (
		.clk(clk),
		.rst(rst),
		.left(left),
		.right(right),
		.bus(bus)
	);

	ball_motion u_ball (
		.clk(clk),
		.rst(rst),
		.bus(bus)
	);

	block_field u_blocks (
		.clk(clk),
		.rst(rst),
		.bus(bus)
	);

	pixel_render u_render (
		.x(x),
		.y(y),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b),
		.bus(bus)
	);

endmodule

//--- breakout_sva.sv
module breakout_sva (
	input logic clk,
	input logic rst,
	input breakout_pkg::game_state_t state,
	input logic tick
);
	import breakout_pkg::*;

	// frame step is a single cycle strobe
	tick_single: assert property (@(posedge clk) disable iff (!rst) tick |=> !tick)
		else $error("tick high on two cycles in a row");

	state_legal: assert property (@(posedge clk) disable iff (!rst)
		state inside {ST_IDLE, ST_SETUP, ST_PLAYING, ST_OVER})
		else $error("state holds an illegal value");

	// play only starts through setup
	no_idle_to_play: assert property (@(posedge clk) disable iff (!rst)
		state == ST_IDLE |=> state != ST_PLAYING)
		else $error("state went from idle straight to playing");

endmodule

bind game_control breakout_sva u_sva (
	.clk(clk),
	.rst(rst),
	.state(state),
	.tick(bus.tick)
);

//--- tb_breakout.sv
`include "breakout_defs.svh"

module tb_breakout;
	import breakout_pkg::*;

	localparam int TICK = 4;
	localparam int GAMES = 4;
	localparam int MAX_TICKS = 20000;
	localparam int GIVE_UP_TICKS = 12000;
	localparam int TIMEOUT = GAMES * MAX_TICKS * TICK + 20000;

	logic clk;
	logic rst;
	logic rst_drive;
	px_x_t x;
	px_y_t y;
	logic left;
	logic right;
	logic start;
	logic serve;
	color_t vga_r;
	color_t vga_g;
	color_t vga_b;

	integer seed;
	int cycles = 0;
	int probe_n;
	int errors;
	int play_ticks;

	// game model
	int m_timer;
	game_state_t m_state;
	int m_bar;
	int m_bx;
	int m_by;
	logic m_dx;
	logic m_dy;
	block_map_t m_blocks;

	breakout_top #(
		.TICK_CYCLES(TICK)
	) UUT (
		.clk(clk),
		.rst(rst),
		.x(x),
		.y(y),
		.left(left),
		.right(right),
		.start(start),
		.serve(serve),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles > TIMEOUT)
		begin
			$display("timeout: the games did not finish within %0d cycles", cycles);
			$display("CHECKS FAILED");
			$fatal(1, "simulation timed out");
		end
	end

	function automatic int block_left(int c);
		return c * `BLOCK_PITCH_X;
	endfunction

	// last column reaches the right screen edge
	function automatic int block_right(int c);
		return (c == `BLOCK_COLS - 1) ? `SCREEN_W : c * `BLOCK_PITCH_X + `BLOCK_W;
	endfunction

	function automatic logic [2:0] column_rgb(int c);
		case (c)
			0: return 3'b100;
			1: return 3'b110;
			2: return 3'b011;
			3: return 3'b010;
			4: return 3'b001;
			default: return 3'b101;
		endcase
	endfunction

	// index of the block box that holds the whole ball, -1 if none
	function automatic int ball_block(int bx, int by);
		int r;
		int c;
		int top;
		ball_block = -1;
		for (r = 0; r < `BLOCK_ROWS; r++)
		begin
			for (c = 0; c < `BLOCK_COLS; c++)
			begin
				top = r * `BLOCK_PITCH_Y;
				if (bx >= block_left(c) && bx + `BALL_SIZE <= block_right(c)
					&& by >= top && by + `BALL_SIZE <= top + `BLOCK_H)
					ball_block = r * `BLOCK_COLS + c;
			end
		end
	endfunction

	function automatic logic [2:0] expected_rgb(int px, int py);
		int r;
		int c;
		int k;
		int inset;
		int top;
		logic [2:0] rgb;
		rgb = 3'b000;
		if (m_state == ST_OVER)
		begin
			if (px > 0 && px < `SCREEN_W && py > 0 && py < `SCREEN_H)
				rgb = (m_blocks == '0) ? 3'b010 : 3'b100;
		end
		else if (m_state != ST_IDLE)
		begin
			for (r = 0; r < `BLOCK_ROWS; r++)
			begin
				for (c = 0; c < `BLOCK_COLS; c++)
				begin
					top = r * `BLOCK_PITCH_Y;
					if (m_blocks[r*`BLOCK_COLS+c] && px > block_left(c) && px < block_right(c)
						&& py > top && py < top + `BLOCK_H)
						rgb = column_rgb(c);
				end
			end
			if (px > m_bar && px < m_bar + `BAR_W && py > `BAR_Y && py < `BAR_Y + `BAR_H)
				rgb = 3'b111;
			// ball rows sit on odd offsets, inset 3 2 0 2 3
			if (py > m_by && py < m_by + `BALL_SIZE && (py - m_by) % 2 == 1)
			begin
				k = (py - m_by) / 2;
				inset = (k == 2) ? 0 : ((k == 1 || k == 3) ? 2 : 3);
				if (px > m_bx + inset && px < m_bx + `BALL_SIZE - inset)
					rgb = 3'b111;
			end
		end
		return rgb;
	endfunction

	// ball, paddle and blocks at their start values
	task automatic model_load_start();
		m_bar = `BAR_START_X;
		m_bx = `BALL_START_X;
		m_by = `BALL_START_Y;
		m_dx = 1'b1;
		m_dy = 1'b1;
		m_blocks = '1;
	endtask

	task automatic model_reset();
		m_timer = 0;
		m_state = ST_IDLE;
		model_load_start();
	endtask

	// one clock of the game, using the inputs the DUT samples at this edge
	task automatic model_step();
		logic tick;
		logic hit;
		logic on_bar;
		int blk;
		game_state_t nstate;
		tick = (m_timer == TICK - 1);
		blk = ball_block(m_bx, m_by);
		hit = (blk >= 0) && m_blocks[blk];
		nstate = m_state;
		case (m_state)
			ST_IDLE: if (start) nstate = ST_SETUP;
			ST_SETUP: if (serve) nstate = ST_PLAYING;
			ST_PLAYING: if (m_by >= `LOSE_Y || m_blocks == '0) nstate = ST_OVER;
			default: if (start) nstate = ST_IDLE;
		endcase
		if (m_state == ST_IDLE || m_state == ST_SETUP)
		begin
			model_load_start();
		end
		else if (m_state == ST_PLAYING && tick)
		begin
			on_bar = m_bx >= m_bar && m_bx <= m_bar + `BAR_W
				&& m_by >= `BAR_Y - `BALL_SIZE && m_by <= `BAR_Y + `BAR_H - `BALL_SIZE;
			if (m_bx + `BALL_SIZE >= `SCREEN_W - `WALL_MARGIN)
				m_dx = 1'b0;
			else if (m_bx <= `WALL_MARGIN)
				m_dx = 1'b1;
			if (m_by < `BALL_DY || hit)
				m_dy = 1'b1;
			else if (on_bar)
				m_dy = 1'b0;
			m_bx = m_dx ? m_bx + `BALL_DX : m_bx - `BALL_DX;
			m_by = m_dy ? m_by + `BALL_DY : m_by - `BALL_DY;
			if (blk >= 0)
				m_blocks[blk] = 1'b0;
			if (left && m_bar >= `WALL_MARGIN)
				m_bar = m_bar - `BAR_STEP;
			else if (right && m_bar + `BAR_W <= `SCREEN_W - 1)
				m_bar = m_bar + `BAR_STEP;
		end
		m_timer = tick ? 0 : m_timer + 1;
		m_state = nstate;
	endtask

	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp)
		begin
			errors++;
			$display("[FAIL] %s: got %h, expected %h (x %h, y %h)", name, got, exp, x, y);
			$display("CHECKS FAILED");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic step_cycle(logic l, logic r, logic st, logic sv);
		int px;
		int py;
		logic [2:0] exp_rgb;
		@(posedge clk);
		if (!rst)
			model_reset();
		else
			model_step();
		probe_n++;
		if (probe_n % 4 == 0)
		begin
			px = m_bx + `BALL_SIZE / 2;
			py = m_by + `BALL_SIZE / 2;
		end
		else
		begin
			px = $random(seed) & 1023;
			py = $random(seed) & 511;
			// screen edge now and then
			case ($random(seed) & 15)
				0: px = 0;
				1: py = 0;
				default: ;
			endcase
		end
		rst <= rst_drive;
		left <= l;
		right <= r;
		start <= st;
		serve <= sv;
		x <= px_x_t'(px);
		y <= px_y_t'(py);
		@(negedge clk);
		exp_rgb = expected_rgb(px, py);
		check_value("vga_r", vga_r, {4{exp_rgb[2]}});
		check_value("vga_g", vga_g, {4{exp_rgb[1]}});
		check_value("vga_b", vga_b, {4{exp_rgb[0]}});
	endtask

	task automatic play_game(logic steer);
		int wait_n;
		int noise;
		int diff;
		logic l;
		logic r;
		wait_n = 8 + ($random(seed) & 15);
		repeat (wait_n) step_cycle($random(seed), $random(seed), 1'b0, 1'b0);
		step_cycle(1'b0, 1'b0, 1'b1, 1'b0);
		// setup holds everything at start values
		repeat (wait_n) step_cycle($random(seed), $random(seed), 1'b0, 1'b0);
		step_cycle(1'b0, 1'b0, 1'b0, 1'b1);
		play_ticks = 0;
		noise = 0;
		while (m_state != ST_OVER)
		begin
			if (m_state == ST_PLAYING && m_timer == TICK - 1)
			begin
				play_ticks++;
				noise = $random(seed) % 25;
			end
			diff = (m_bx + `BALL_SIZE / 2 + noise) - (m_bar + `BAR_W / 2);
			if (play_ticks > GIVE_UP_TICKS)
			begin
				// pull the paddle away so the ball is lost
				l = (diff > 0);
				r = (diff <= 0);
			end
			else if (steer)
			begin
				l = (diff < -2);
				r = (diff > 2);
			end
			else
			begin
				l = $random(seed);
				r = $random(seed);
			end
			step_cycle(l, r, 1'b0, 1'b0);
		end
		$display("game over after %0d ticks, %0d blocks left", play_ticks, $countones(m_blocks));
		repeat (wait_n) step_cycle(1'b0, 1'b0, 1'b0, 1'b0);
		step_cycle(1'b0, 1'b0, 1'b1, 1'b0);
	endtask

	initial
	begin
		seed = 28088;
		errors = 0;
		probe_n = 0;
		rst = 1'b0;
		rst_drive = 1'b0;
		left = 1'b0;
		right = 1'b0;
		start = 1'b0;
		serve = 1'b0;
		x = '0;
		y = '0;
		model_reset();
		repeat (10) step_cycle(1'b0, 1'b0, 1'b0, 1'b0);
		rst_drive = 1'b1;
		for (int g = 0; g < GAMES; g++)
			play_game(g % 2 == 1);
		repeat (20) step_cycle(1'b0, 1'b0, 1'b0, 1'b0);
		if (errors == 0)
		begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
		else
		begin
			$display("CHECKS FAILED");
			$fatal(1, "%0d errors", errors);
		end
	end

endmodule

//--- compile.f
+incdir+.
breakout_pkg.sv
game_bus_if.sv
game_control.sv
paddle_ctrl.sv
ball_motion.sv
block_field.sv
pixel_render.sv
breakout_top.sv
breakout_sva.sv
tb_breakout.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --assert -Wno-fatal -j 0
TOP = tb_breakout
FILELIST = compile.f
SRCS := $(filter-out +%,$(shell cat $(FILELIST))) breakout_defs.svh
BIN = obj_dir/V$(TOP)
LOG = sim.log
PASS_MSG = ALL CHECKS PASSED

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
